// ==== include/vic_palette.svh ====
// rgb per colour index, 6 bits per gun
localparam rgb_t PALETTE_RGB [16] = '{
  '{6'd0,  6'd0,  6'd0},  // black
  '{6'd63, 6'd63, 6'd63}, // white
  '{6'd26, 6'd13, 6'd10}, // red
  '{6'd28, 6'd41, 6'd44}, // cyan
  '{6'd27, 6'd15, 6'd33}, // purple
  '{6'd22, 6'd35, 6'd16}, // green
  '{6'd13, 6'd10, 6'd30}, // blue
  '{6'd46, 6'd49, 6'd27}, // yellow
  '{6'd27, 6'd19, 6'd9},  // orange
  '{6'd16, 6'd14, 6'd0},  // brown
  '{6'd38, 6'd25, 6'd22}, // light red
  '{6'd17, 6'd17, 6'd17}, // dark grey
  '{6'd27, 6'd27, 6'd27}, // grey
  '{6'd38, 6'd52, 6'd33}, // light green
  '{6'd27, 6'd23, 6'd45}, // light blue
  '{6'd37, 6'd37, 6'd37}  // light grey
};

// luma level per index, all above the blanking pedestal
localparam logic [5:0] PALETTE_LUMA [16] = '{
  6'd12, 6'd63, 6'd26, 6'd44, 6'd30, 6'd38, 6'd22, 6'd52,
  6'd30, 6'd22, 6'd38, 6'd26, 6'd36, 6'd52, 6'd36, 6'd46
};

// carrier amplitude per index, greys have none
localparam logic [5:0] PALETTE_SAT [16] = '{
  6'd0,  6'd0,  6'd12, 6'd12, 6'd14, 6'd14, 6'd12, 6'd10,
  6'd12, 6'd10, 6'd12, 6'd0,  6'd0,  6'd12, 6'd12, 6'd0
};

// ==== hdl/vic_timing_pkg.sv ====
package vic_timing_pkg;

  // chip model as seen on the select pins
  typedef logic [1:0] chip_t;

  localparam chip_t NTSC_6567R8  = 2'd0;
  localparam chip_t PAL_6569     = 2'd1;
  localparam chip_t NTSC_6567R56A = 2'd2; // value 3 is folded onto pal by the timer

  typedef logic [9:0] dot_t;  // up to 520 dots
  typedef logic [8:0] line_t; // up to 312 lines

  // per model geometry, indexed by chip_t
  localparam dot_t  LINE_DOTS   [3] = '{10'd520, 10'd504, 10'd512};
  localparam line_t FRAME_LINES [3] = '{9'd263, 9'd312, 9'd262};

  // horizontal sync window in dots
  localparam dot_t HSYNC_START = 10'd400;
  localparam dot_t HSYNC_LEN   = 10'd40;

  // vertical sync window in lines
  localparam line_t VSYNC_LINE = 9'd0;
  localparam line_t VSYNC_LEN  = 9'd3;

  // visible area, same on all models
  localparam dot_t  ACTIVE_X0 = 10'd24;
  localparam dot_t  ACTIVE_W  = 10'd320;
  localparam line_t ACTIVE_Y0 = 9'd16;
  localparam line_t ACTIVE_H  = 9'd200;

endpackage

// ==== hdl/vic_pixel_pkg.sv ====
package vic_pixel_pkg;

  typedef logic [3:0] color_t; // vic colour index 0..15

  // one pixel from the graphics side
  typedef struct packed {
    color_t colour;
    logic   border; // forces border colour
  } pixel_t;

  // palette output, 6 bits per gun
  typedef struct packed {
    logic [5:0] red;
    logic [5:0] green;
    logic [5:0] blue;
  } rgb_t;

  // composite pair for the s-video style output
  typedef struct packed {
    logic [5:0] luma;
    logic [5:0] chroma;
  } comp_t;

  // timer decode, travels down the delay line
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic active;
  } sync_t;

  // fifo size doubles as the host credit budget after reset
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // light blue, shown for border and on underrun
  localparam color_t BORDER_COLOR = 4'd14;

  // composite levels
  localparam logic [5:0] CHROMA_MID = 6'd32; // zero colour carrier
  localparam logic [5:0] BLANK_LUMA = 6'd8;  // blanking pedestal
  localparam logic [5:0] SYNC_LUMA  = 6'd0;  // sync tip

endpackage

// ==== hdl/raster_timer.sv ====
`timescale 1ns/1ns

module raster_timer
  import vic_timing_pkg::*;
  import vic_pixel_pkg::*;
(
  input  logic  clk_col4x_pal,
  input  logic  arst_n,
  input  chip_t chip,     // async select from switch or config
  output sync_t sync,
  output logic  pix_req,  // pop one pixel this cycle
  output dot_t  dot,
  output chip_t chip_cur  // model in effect for this frame
);

  chip_t chip_meta;
  chip_t chip_sync;
  chip_t chip_fold;
  dot_t  dot_q;
  line_t line_q;
  dot_t  dot_last;
  line_t line_last;
  logic  line_end;
  logic  frame_end;

  // model 3 has no geometry of its own, run it as pal
  assign chip_fold = (chip_sync == 2'd3) ? PAL_6569 : chip_sync;

  assign dot_last  = LINE_DOTS[chip_cur] - dot_t'(1);
  assign line_last = FRAME_LINES[chip_cur] - line_t'(1);
  assign line_end  = (dot_q == dot_last);
  assign frame_end = line_end && (line_q == line_last);

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      chip_meta <= PAL_6569;
      chip_sync <= PAL_6569;
      chip_cur  <= PAL_6569;
    end else begin
      chip_meta <= chip;       // two flop synchroniser
      chip_sync <= chip_meta;
      if (frame_end) begin
        chip_cur <= chip_fold; // new geometry starts at dot 0 line 0
      end
    end
  end

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      dot_q  <= '0;
      line_q <= '0;
    end else if (line_end) begin
      dot_q  <= '0;
      line_q <= frame_end ? line_t'(0) : line_q + line_t'(1);
    end else begin
      dot_q <= dot_q + dot_t'(1);
    end
  end

  // window decode as offset compare, wraps below the start
  assign sync.hsync  = dot_t'(dot_q - HSYNC_START) < HSYNC_LEN;
  assign sync.vsync  = line_t'(line_q - VSYNC_LINE) < VSYNC_LEN;
  assign sync.active = (dot_t'(dot_q - ACTIVE_X0) < ACTIVE_W) &&
                       (line_t'(line_q - ACTIVE_Y0) < ACTIVE_H);

  assign pix_req = sync.active; // one pop per visible dot
  assign dot     = dot_q;

  // counter must stay inside the line even across a model switch
  a_dot_in_line: assert property (@(posedge clk_col4x_pal) disable iff (!arst_n)
    dot_q < LINE_DOTS[chip_cur] && line_q < FRAME_LINES[chip_cur]);

endmodule

// ==== hdl/pixel_credit_fifo.sv ====
`timescale 1ns/1ns

module pixel_credit_fifo
  import vic_pixel_pkg::*;
(
  input  logic   clk_col4x_pal,
  input  logic   arst_n,
  input  pixel_t pix_in,
  input  logic   pix_push,
  input  logic   pop,       // from the timer, once per visible dot
  output pixel_t cur_pix,   // head, valid in the pop cycle
  output logic   credit,    // one pulse per real entry consumed
  output logic   underrun   // sticky until reset
);

  pixel_t             mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               empty;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign empty   = (count == '0);
  assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign do_push = pix_push && !full; // a push into a full fifo is dropped
  assign do_pop  = pop && !empty;

  // payload storage
  always_ff @(posedge clk_col4x_pal) begin
    if (do_push) begin
      mem[wr_ptr] <= pix_in;
    end
  end

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // none or both
      endcase
    end
  end

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      credit   <= 1'b0;
      underrun <= 1'b0;
    end else begin
      credit <= do_pop;             // hand the slot back to the host
      if (pop && empty) begin
        underrun <= 1'b1;           // display went on without data
      end
    end
  end

  // empty head becomes a border pixel, the display never stalls
  always_comb begin
    if (empty) begin
      cur_pix = '{colour: BORDER_COLOR, border: 1'b1};
    end else begin
      cur_pix = mem[rd_ptr];
    end
  end

  // host must respect its credits
  a_no_push_full: assert property (@(posedge clk_col4x_pal) disable iff (!arst_n)
    !(pix_push && full));

endmodule

// ==== hdl/rgb_palette.sv ====
`timescale 1ns/1ns

module rgb_palette
  import vic_pixel_pkg::*;
(
  input  logic   clk_col4x_pal,
  input  logic   arst_n,
  input  pixel_t pix,
  output rgb_t   rgb
);

  `include "vic_palette.svh"

  color_t idx;

  // border flag wins over the pixel's own colour
  assign idx = pix.border ? BORDER_COLOR : pix.colour;

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      rgb <= '0;                // black until the first pixel
    end else begin
      rgb <= PALETTE_RGB[idx];  // one cycle lookup
    end
  end

endmodule

// ==== hdl/luma_chroma_gen.sv ====
`timescale 1ns/1ns

module luma_chroma_gen
  import vic_pixel_pkg::*;
(
  input  logic       clk_col4x_pal,
  input  logic       arst_n,
  input  pixel_t     pix,
  input  logic [1:0] phase,  // dot position mod 4
  output comp_t      comp
);

  `include "vic_palette.svh"

  color_t     idx;
  logic [5:0] sat;
  logic [5:0] chroma_nxt;

  assign idx = pix.border ? BORDER_COLOR : pix.colour;
  assign sat = PALETTE_SAT[idx];

  // square carrier at a quarter of the dot rate
  // phases 0,1 swing high, 2,3 swing low
  always_comb begin
    if (phase[1]) begin
      chroma_nxt = CHROMA_MID - sat;
    end else begin
      chroma_nxt = CHROMA_MID + sat;
    end
  end

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      comp.luma   <= BLANK_LUMA;  // pedestal, no carrier
      comp.chroma <= CHROMA_MID;
    end else begin
      comp.luma   <= PALETTE_LUMA[idx];
      comp.chroma <= chroma_nxt;
    end
  end

endmodule

// ==== hdl/video_combiner.sv ====
`timescale 1ns/1ns

module video_combiner
  import vic_pixel_pkg::*;
(
  input  logic       clk_col4x_pal,
  input  logic       arst_n,
  input  sync_t      sync_in,   // straight from the timer
  input  rgb_t       rgb,       // one cycle behind the timer
  input  comp_t      comp,
  output logic       hsync,
  output logic       vsync,
  output logic [5:0] red,
  output logic [5:0] green,
  output logic [5:0] blue,
  output logic [5:0] luma,
  output logic [5:0] chroma,
  output logic       luma_sink  // pulls luma into the sync tip
);

  sync_t sync_d1; // lines sync up with the colour path registers

  always_ff @(posedge clk_col4x_pal or negedge arst_n) begin
    if (!arst_n) begin
      sync_d1   <= '0;
      hsync     <= 1'b0;
      vsync     <= 1'b0;
      red       <= '0;
      green     <= '0;
      blue      <= '0;
      luma      <= BLANK_LUMA;
      chroma    <= CHROMA_MID;
      luma_sink <= 1'b0;
    end else begin
      sync_d1 <= sync_in;
      hsync   <= sync_d1.hsync;
      vsync   <= sync_d1.vsync;
      if (sync_d1.active) begin
        {red, green, blue} <= rgb;
        luma               <= comp.luma;
        chroma             <= comp.chroma;
      end else begin
        {red, green, blue} <= '0;   // blanked
        luma               <= BLANK_LUMA;
        chroma             <= CHROMA_MID;
      end
      // sync tip overrides the pedestal
      if (sync_d1.hsync || sync_d1.vsync) begin
        luma <= SYNC_LUMA;
      end
      luma_sink <= sync_d1.hsync || sync_d1.vsync;
    end
  end

  // timer geometry must keep the visible area clear of hsync
  a_active_not_hsync: assert property (@(posedge clk_col4x_pal) disable iff (!arst_n)
    !(sync_in.active && sync_in.hsync));

endmodule

// ==== hdl/vic_video_top.sv ====
`timescale 1ns/1ns

module vic_video_top
  import vic_timing_pkg::*;
  import vic_pixel_pkg::*;
(
  input  logic       clk_col4x_pal,
  input  logic       arst_n,
  input  chip_t      chip,       // model select, any clock domain
  input  pixel_t     pix_in,     // host pixel stream
  input  logic       pix_push,
  output logic       credit,     // back to the host
  output logic       underrun,
  output logic       hsync,
  output logic       vsync,
  output logic [5:0] red,
  output logic [5:0] green,
  output logic [5:0] blue,
  output logic [5:0] luma,
  output logic [5:0] chroma,
  output logic       luma_sink
);

  sync_t  sync;
  logic   pix_req;
  dot_t   dot;
  pixel_t cur_pix;
  rgb_t   rgb;
  comp_t  comp;

  raster_timer u_timer (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .chip          (chip),
    .sync          (sync),
    .pix_req       (pix_req),
    .dot           (dot),
    .chip_cur      ()             // debug only, no pin on this board
  );

  pixel_credit_fifo u_fifo (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .pix_in        (pix_in),
    .pix_push      (pix_push),
    .pop           (pix_req),
    .cur_pix       (cur_pix),
    .credit        (credit),
    .underrun      (underrun)
  );

  rgb_palette u_rgb (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .pix           (cur_pix),
    .rgb           (rgb)
  );

  luma_chroma_gen u_comp (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .pix           (cur_pix),
    .phase         (dot[1:0]),    // carrier phase from the dot count
    .comp          (comp)
  );

  video_combiner u_comb (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .sync_in       (sync),
    .rgb           (rgb),
    .comp          (comp),
    .hsync         (hsync),
    .vsync         (vsync),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .luma          (luma),
    .chroma        (chroma),
    .luma_sink     (luma_sink)
  );

endmodule

// ==== dv/tb_vic_video.sv ====
`timescale 1ns/1ns

module tb_vic_video
  import vic_timing_pkg::*;
  import vic_pixel_pkg::*;
();

  // reference geometry, pal model
  localparam int PAL_DOTS   = 504;
  localparam int NTSC_DOTS  = 520;
  localparam int PAL_LINES  = 312;
  localparam int HS_START   = 400;
  localparam int HS_LEN     = 40;
  localparam int VS_LEN     = 3;
  localparam int X0         = 24;
  localparam int W          = 320;
  localparam int Y0         = 16;
  localparam int H          = 200;
  localparam int DEPTH      = 8;  // host credits after reset
  localparam int BORDER_IDX = 14;
  localparam int MID        = 32;
  localparam int BLANK_LVL  = 8;
  localparam int SYNC_LVL   = 0;
  localparam int WAIT_LIMIT = 2 * NTSC_DOTS * PAL_LINES; // two frames of the longest line

  logic       clk_col4x_pal;
  logic       arst_n;
  chip_t      chip;
  pixel_t     pix_in;
  logic       pix_push;
  logic       credit, underrun, hsync, vsync, luma_sink;
  logic [5:0] red, green, blue, luma, chroma;

  // reference palette, {red, green, blue} per index
  logic [17:0] ref_rgb [16] = '{
    {6'd0, 6'd0, 6'd0}, {6'd63, 6'd63, 6'd63}, {6'd26, 6'd13, 6'd10}, {6'd28, 6'd41, 6'd44},
    {6'd27, 6'd15, 6'd33}, {6'd22, 6'd35, 6'd16}, {6'd13, 6'd10, 6'd30}, {6'd46, 6'd49, 6'd27},
    {6'd27, 6'd19, 6'd9}, {6'd16, 6'd14, 6'd0}, {6'd38, 6'd25, 6'd22}, {6'd17, 6'd17, 6'd17},
    {6'd27, 6'd27, 6'd27}, {6'd38, 6'd52, 6'd33}, {6'd27, 6'd23, 6'd45}, {6'd37, 6'd37, 6'd37}
  };
  int ref_luma [16] = '{12, 63, 26, 44, 30, 38, 22, 52, 30, 22, 38, 26, 36, 52, 36, 46};
  int ref_sat  [16] = '{0, 0, 12, 12, 14, 14, 12, 10, 12, 10, 12, 0, 0, 12, 12, 0};

  int     err_count, check_count, test_count;
  bit     check_en;              // monitor compares pins when set
  int     host_credits;
  color_t host_q [$];            // colours waiting at the host
  color_t fifo_q [$];            // model of the DUT FIFO
  color_t disp_q [$];            // popped pixels on their way to the pins
  int     pdot [3];              // timer position now, 1 and 2 cycles back
  int     pline [3];
  bit     exp_credit, exp_underrun;
  int     pushes, real_pops, credit_pulses, max_fill, line_samples;
  logic   hsync_prev;

  vic_video_top uut (
    .clk_col4x_pal (clk_col4x_pal),
    .arst_n        (arst_n),
    .chip          (chip),
    .pix_in        (pix_in),
    .pix_push      (pix_push),
    .credit        (credit),
    .underrun      (underrun),
    .hsync         (hsync),
    .vsync         (vsync),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .luma          (luma),
    .chroma        (chroma),
    .luma_sink     (luma_sink)
  );

  initial begin
    clk_col4x_pal = 1'b0;
    forever #20 clk_col4x_pal = ~clk_col4x_pal; // 40 ns period
  end

  function automatic bit in_rows(int l);
    return l >= Y0 && l < Y0 + H;
  endfunction

  function automatic bit in_active(int d, int l);
    return d >= X0 && d < X0 + W && in_rows(l);
  endfunction

  function automatic logic pin_level(string pin);
    case (pin)
      "hsync": return hsync;
      "vsync": return vsync;
      default: return underrun;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic fail_timeout(string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic wait_level(input string pin, input logic level, input int limit,
                            output int cycles);
    cycles = 0;
    while (pin_level(pin) !== level) begin
      @(posedge clk_col4x_pal);
      #1;
      cycles++;
      if (cycles > limit) begin
        fail_timeout($sformatf("%s did not go %s within %0d cycles", pin,
                               level ? "high" : "low", limit));
      end
    end
  endtask

  task automatic test_done(string name, int errs_before);
    test_count++;
    $display("%s: done, %0d errors", name, err_count - errs_before);
  endtask

  // host spends a credit per push and regains one per credit pulse
  initial begin : host
    pix_in   = '0;
    pix_push = 1'b0;
    forever begin
      @(posedge clk_col4x_pal);
      #1;
      if (!arst_n) host_credits = DEPTH;
      else if (credit) host_credits++;
      #1;
      if (arst_n && host_q.size() > 0 && host_credits > 0) begin
        pix_in   = '{colour: host_q.pop_front(), border: 1'b0};
        pix_push = 1'b1;
        host_credits--;
      end else begin
        pix_push = 1'b0;
      end
    end
  end

  task automatic reset_model();
    for (int i = 0; i < 3; i++) begin
      pdot[i]  = 0;
      pline[i] = 0;
    end
    fifo_q.delete();
    disp_q.delete();
    exp_credit   = 1'b0;
    exp_underrun = 1'b0;
    line_samples = 0;
    hsync_prev   = 1'b0;
  endtask

  // reference of one clock edge pops, pushes and advances the raster
  task automatic track_edge();
    int fill;
    fill       = fifo_q.size();
    exp_credit = 1'b0;
    if (in_active(pdot[0], pline[0])) begin
      if (fill > 0) begin
        disp_q.push_back(fifo_q.pop_front());
        exp_credit = 1'b1;
        real_pops++;
      end else begin
        disp_q.push_back(color_t'(BORDER_IDX)); // empty head shows border
        exp_underrun = 1'b1;
      end
    end
    if (pix_push) begin
      if (fill >= DEPTH) begin
        err_count++;
        $display("Host pushed into a full FIFO at %0t ns", $time);
      end
      fifo_q.push_back(pix_in.colour);
      pushes++;
      if (fifo_q.size() > max_fill) max_fill = fifo_q.size();
    end
    pdot[2]  = pdot[1];
    pline[2] = pline[1];
    pdot[1]  = pdot[0];
    pline[1] = pline[0];
    if (pdot[0] == PAL_DOTS - 1) begin
      pdot[0]  = 0;
      pline[0] = (pline[0] == PAL_LINES - 1) ? 0 : pline[0] + 1;
    end else begin
      pdot[0]++;
    end
    if (credit) credit_pulses++;
  endtask

  // pins now show the timer state of two cycles back
  task automatic compare_pins();
    color_t      e;
    bit          act2;
    bit          hs2;
    bit          vs2;
    logic [17:0] exp_rgb;
    int          exp_luma;
    int          exp_chroma;
    act2       = in_active(pdot[2], pline[2]);
    hs2        = pdot[2] >= HS_START && pdot[2] < HS_START + HS_LEN;
    vs2        = pline[2] < VS_LEN;
    exp_rgb    = '0;
    exp_luma   = (hs2 || vs2) ? SYNC_LVL : BLANK_LVL;
    exp_chroma = MID;
    if (act2 && disp_q.size() > 0) begin
      e          = disp_q.pop_front();
      exp_rgb    = ref_rgb[e];
      exp_luma   = ref_luma[e];
      exp_chroma = (pdot[2] % 4 < 2) ? MID + ref_sat[e] : MID - ref_sat[e];
    end
    if (!luma_sink && luma != BLANK_LVL) line_samples++; // picture level seen on the pins
    if (hsync && !hsync_prev) begin
      if (check_en) check_value("active samples per line", in_rows(pline[2]) ? W : 0,
                                line_samples);
      line_samples = 0;
    end
    hsync_prev = hsync;
    if (check_en) begin
      check_value("hsync", hs2, hsync);
      check_value("vsync", vs2, vsync);
      check_value("luma_sink", hs2 || vs2, luma_sink);
      check_value("red/green/blue", exp_rgb, {red, green, blue});
      check_value("luma", exp_luma, luma);
      check_value("chroma", exp_chroma, chroma);
      check_value("credit", exp_credit, credit);
      check_value("underrun", exp_underrun, underrun);
    end
  endtask

  initial begin : monitor
    forever begin
      @(posedge clk_col4x_pal);
      #1;
      if (!arst_n) begin
        reset_model();
      end else begin
        track_edge();
        compare_pins();
      end
    end
  end

  task automatic check_idle();
    check_value("hsync", 0, hsync);
    check_value("vsync", 0, vsync);
    check_value("credit", 0, credit);
    check_value("underrun", 0, underrun);
    check_value("luma_sink", 0, luma_sink);
    check_value("red/green/blue", 0, {red, green, blue});
  endtask

  task automatic test_reset_levels();
    int errs;
    errs = err_count;
    #1;
    check_idle();                 // still in reset
    #1 arst_n = 1'b1;
    @(posedge clk_col4x_pal);
    #1;
    check_idle();                 // timer decode not through the delay line yet
    repeat (2) @(posedge clk_col4x_pal);
    #1;
    check_value("vsync", 1, vsync); // line 0 is a vsync line
    check_value("hsync", 0, hsync);
    check_value("luma_sink", 1, luma_sink);
    check_value("luma", SYNC_LVL, luma);
    check_value("chroma", MID, chroma);
    check_value("red/green/blue", 0, {red, green, blue});
    check_value("underrun", 0, underrun);
    test_done("reset levels", errs);
  endtask

  task automatic test_pixel_stream(int n);
    int errs;
    int cycles;
    errs     = err_count;
    check_en = 1'b1;
    repeat (n) host_q.push_back(color_t'($urandom % 16));
    cycles = 0;
    while (host_q.size() > 0 || pix_push || fifo_q.size() > 0) begin
      @(posedge clk_col4x_pal);
      #3;
      cycles++;
      if (cycles > WAIT_LIMIT) fail_timeout("pushed pixels were not all displayed");
    end
    check_value("underrun", 0, underrun); // credits kept the FIFO fed
    test_done("pixel stream", errs);
  endtask

  task automatic test_credit_underrun();
    int errs;
    int cycles;
    errs = err_count;
    wait_level("underrun", 1'b1, WAIT_LIMIT, cycles);
    repeat (2 * PAL_DOTS) begin   // border lines, flag must hold
      @(posedge clk_col4x_pal);
      #3;
      check_value("underrun", 1, underrun);
    end
    check_value("credit pulses", real_pops, credit_pulses);
    check_value("host credits", DEPTH, host_credits); // every pushed pixel handed back
    check_value("FIFO fill within depth", 1, max_fill <= DEPTH);
    test_done("credit and underrun", errs);
  endtask

  task automatic measure_hsync(int exp_period);
    int hi;
    int lo;
    int cycles;
    wait_level("hsync", 1'b0, WAIT_LIMIT, cycles);
    wait_level("hsync", 1'b1, WAIT_LIMIT, cycles);
    wait_level("hsync", 1'b0, WAIT_LIMIT, hi);
    wait_level("hsync", 1'b1, WAIT_LIMIT, lo);
    check_value("hsync length", HS_LEN, hi);
    check_value("hsync period", exp_period, hi + lo);
  endtask

  task automatic test_sync_timing();
    int errs;
    int cycles;
    errs     = err_count;
    check_en = 1'b0;              // reference raster only follows pal
    measure_hsync(PAL_DOTS);
    #1 chip = NTSC_6567R8;
    wait_level("vsync", 1'b0, WAIT_LIMIT, cycles);
    wait_level("vsync", 1'b1, WAIT_LIMIT, cycles); // new model from this frame on
    measure_hsync(NTSC_DOTS);
    test_done("sync timing", errs);
  endtask

  initial begin : main
    void'($urandom(32'h2a59_68aa));
    arst_n = 1'b0;
    chip   = PAL_6569;
    repeat (4) @(posedge clk_col4x_pal);
    test_reset_levels();
    test_pixel_stream(1000);      // a bit over three visible lines
    test_credit_underrun();
    test_sync_timing();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
hdl/vic_timing_pkg.sv
hdl/vic_pixel_pkg.sv
hdl/raster_timer.sv
hdl/pixel_credit_fifo.sv
hdl/rgb_palette.sv
hdl/luma_chroma_gen.sv
hdl/video_combiner.sv
hdl/vic_video_top.sv
dv/tb_vic_video.sv

// ==== Bender.yml ====
package:
  name: vic_video

sources:
  - include_dirs:
      - include
    files:
      - hdl/vic_timing_pkg.sv
      - hdl/vic_pixel_pkg.sv
      - hdl/raster_timer.sv
      - hdl/pixel_credit_fifo.sv
      - hdl/rgb_palette.sv
      - hdl/luma_chroma_gen.sv
      - hdl/video_combiner.sv
      - hdl/vic_video_top.sv
  - target: test
    files:
      - dv/tb_vic_video.sv
